// ==== Makefile ====
# Verilator flow for the load-store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
SEED_LOG  ?= sim.log
LINT_LOG  ?= lint.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST) \
		> $(LINT_LOG) 2>&1; status=$$?; cat $(LINT_LOG); exit $$status

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -Mdir $(OBJ_DIR) \
		-f $(FILELIST) > $(SEED_LOG) 2>&1 || (cat $(SEED_LOG); exit 1)
	-./$(OBJ_DIR)/V$(TOP) >> $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@grep -q "$(PASS_MSG)" $(SEED_LOG) || (echo "pass message not found in $(SEED_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG) $(LINT_LOG)

// ==== filelist.f ====
hdl/lsu_pkg.sv
hdl/lsu_fsm.sv
hdl/lsu_wdata_align.sv
hdl/lsu_rdata_align.sv
hdl/lsu_top.sv
tb/tb_lsu.sv

// ==== hdl/lsu_fsm.sv ====
// load-store request FSM
// splits misaligned words and half words into two bus accesses, collects
// bus errors of both parts and holds the last address for the trap value

module lsu_fsm import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32  // at least 3
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // execute stage
  input  logic                 data_req_ex_i,
  input  logic                 data_we_ex_i,
  input  lsu_size_e            data_type_ex_i,
  input  logic [AddrWidth-1:0] adder_result_ex_i,

  // bus handshake
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  output logic                 data_req_o,

  // back to the execute stage
  output logic                 addr_incr_req_o,  // core drives address + 4
  output logic                 data_valid_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic                 busy_o,
  output logic [AddrWidth-1:0] addr_last_o,

  // data path steering
  output logic                 misaligned_second_o,
  output logic                 ctrl_update_o,
  output logic                 rdata_update_o
);

  lsu_state_e state_q, state_d;

  logic [OffsetWidth-1:0] offset;
  logic                   split_access;
  logic                   second_q, second_d;  // high once the first part is granted
  logic                   err_q, err_d;        // bus error seen on the first part
  logic                   we_q;                // write enable of the access in flight
  logic                   addr_update;
  logic                   access_err;
  logic [AddrWidth-1:0]   addr_last_q;

  assign offset = adder_result_ex_i[OffsetWidth-1:0];

  // word off a word boundary, or half word in the top lane
  assign split_access = ((data_type_ex_i == size_word) && (offset != '0)) ||
                        ((data_type_ex_i == size_half) && (&offset));

  //////////////////////////////////////////////////////////////////////
  // next state and handshake outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    second_d        = second_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    data_valid_o    = 1'b0;
    access_err      = 1'b0;
    addr_update     = 1'b0;
    ctrl_update_o   = 1'b0;
    rdata_update_o  = 1'b0;

    case (state_q)
      st_idle: begin
        if (data_req_ex_i) begin
          data_req_o = 1'b1;
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            addr_update   = 1'b1;
            second_d      = split_access;
            state_d       = split_access ? st_wait_rvalid_mis : st_wait_rvalid;
          end else begin
            state_d       = split_access ? st_wait_gnt_mis : st_wait_gnt;
          end
        end
      end

      st_wait_gnt_mis: begin
        data_req_o = 1'b1;  // hold first part until granted
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = 1'b1;
          second_d      = 1'b1;
          state_d       = st_wait_rvalid_mis;
        end
      end

      st_wait_rvalid_mis: begin
        // second part goes out while the first response is still pending
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          rdata_update_o = ~we_q;                      // keep upper bytes of a load
          addr_update    = data_gnt_i & ~data_err_i;   // first failing address stays
          state_d        = data_gnt_i ? st_wait_rvalid : st_wait_gnt;
        end else if (data_gnt_i) begin
          state_d = st_wait_rvalid_done;               // two grants outstanding
        end
      end

      st_wait_gnt: begin
        data_req_o      = 1'b1;
        addr_incr_req_o = second_q;  // only the second part needs address + 4
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          addr_update   = ~err_q;
          state_d       = st_wait_rvalid;
        end
      end

      st_wait_rvalid: begin
        if (data_rvalid_i) begin
          data_valid_o = 1'b1;
          access_err   = err_q | data_err_i;  // error from either part
          second_d     = 1'b0;
          state_d      = st_idle;
        end
      end

      st_wait_rvalid_done: begin
        // address + 4 stays so the second address can be captured
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d          = data_err_i;
          addr_update    = ~data_err_i;
          rdata_update_o = ~we_q;
          state_d        = st_wait_rvalid;
        end
      end

      default: begin
        state_d = st_idle;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and access registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= st_idle;
      second_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      second_q <= second_d;
      err_q    <= err_d;
    end
  end

  // write enable picks load or store error at the end
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_update_o) begin
      we_q <= data_we_ex_i;
    end
  end

  // last granted address, full byte address for the trap value
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= adder_result_ex_i;
    end
  end

  assign addr_last_o         = addr_last_q;
  assign misaligned_second_o = second_q;
  assign load_err_o          = access_err & ~we_q;
  assign store_err_o         = access_err &  we_q;
  assign busy_o              = (state_q != st_idle);

endmodule

// ==== hdl/lsu_pkg.sv ====
// load-store unit shared definitions
// data sizes, access size opcode and request state encoding

package lsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path sizes
  //////////////////////////////////////////////////////////////////////

  // the lane logic is written for a 32-bit word of four byte lanes
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned NumBytes    = DataWidth / 8;  // byte-enable width
  localparam int unsigned OffsetWidth = 2;              // byte offset inside a word

  //////////////////////////////////////////////////////////////////////
  // access size opcode, as sent by the execute stage
  //////////////////////////////////////////////////////////////////////

  // 2'b11 has no name of its own, every decoder treats it as a byte
  typedef enum logic [1:0] {
    size_word = 2'b00,
    size_half = 2'b01,
    size_byte = 2'b10
  } lsu_size_e;

  //////////////////////////////////////////////////////////////////////
  // request FSM states
  //////////////////////////////////////////////////////////////////////

  // _mis states belong to the first part of a split access
  typedef enum logic [2:0] {
    st_idle,              // no access, first request goes out combinationally
    st_wait_gnt_mis,      // first part requested, grant pending
    st_wait_rvalid_mis,   // first part granted, second part requested
    st_wait_gnt,          // single or second part waiting for grant
    st_wait_rvalid,       // last response pending
    st_wait_rvalid_done   // both granted, first response still pending
  } lsu_state_e;

endpackage

// ==== hdl/lsu_rdata_align.sv ====
// load side of the load-store unit
// captures the access control at grant, keeps the upper bytes of a first
// response and returns the realigned, zero- or sign-extended load data

module lsu_rdata_align import lsu_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // steering from the FSM
  input  logic                   ctrl_update_i,        // access granted
  input  logic                   rdata_update_i,       // first response of a split load
  input  logic                   misaligned_second_i,  // split access in its second part

  // execute stage fields, sampled at grant
  input  logic [OffsetWidth-1:0] adder_result_ex_i,
  input  lsu_size_e              data_type_ex_i,
  input  logic                   data_sign_ext_ex_i,

  input  logic [DataWidth-1:0]   data_rdata_i,
  output logic [DataWidth-1:0]   data_rdata_ex_o
);

  logic [OffsetWidth-1:0] offset_q;
  lsu_size_e              size_q;
  logic                   sign_ext_q;

  logic [DataWidth-1:8]   rdata_q;       // upper three bytes of the first response
  logic [DataWidth-1:0]   first_word;
  logic [DataWidth-1:0]   rdata_merged;  // load bytes moved down to lane 0
  logic                   sign_half;
  logic                   sign_byte;

  //////////////////////////////////////////////////////////////////////
  // captured access control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      size_q     <= size_word;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= adder_result_ex_i;  // second part carries the same low bits
      size_q     <= data_type_ex_i;
      sign_ext_q <= data_sign_ext_ex_i;
    end
  end

  // partial word, lane 0 is never part of a split load
  always_ff @(posedge clk_i) begin
    if (rdata_update_i) begin
      rdata_q <= data_rdata_i[DataWidth-1:8];
    end
  end

  // lane 0 is filler here and never selected
  assign first_word = {rdata_q, data_rdata_i[7:0]};

  //////////////////////////////////////////////////////////////////////
  // realignment
  //////////////////////////////////////////////////////////////////////

  // lane j of the result comes from bus lane j + offset
  // in the second part of a split, lanes that did not wrap past the
  // word boundary were delivered by the first response
  always_comb begin
    logic [OffsetWidth-1:0] src;
    for (int unsigned j = 0; j < NumBytes; j++) begin
      src = OffsetWidth'(j) + offset_q;
      if (misaligned_second_i && ((j + offset_q) < NumBytes)) begin
        rdata_merged[8*j +: 8] = first_word[8*src +: 8];
      end else begin
        rdata_merged[8*j +: 8] = data_rdata_i[8*src +: 8];  // current response
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // size select and extension
  //////////////////////////////////////////////////////////////////////

  assign sign_half = sign_ext_q & rdata_merged[15];  // zero fill when cleared
  assign sign_byte = sign_ext_q & rdata_merged[7];

  always_comb begin
    case (size_q)
      size_word: data_rdata_ex_o = rdata_merged;
      size_half: data_rdata_ex_o = {{(DataWidth-16){sign_half}}, rdata_merged[15:0]};
      default:   data_rdata_ex_o = {{(DataWidth-8){sign_byte}}, rdata_merged[7:0]};
    endcase
  end

endmodule

// ==== hdl/lsu_top.sv ====
// load-store unit top level
// connects the request FSM and the store and load data paths between the
// execute stage and the word-aligned request/grant/response data bus

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // execute stage
  input  logic                 data_req_ex_i,
  input  logic                 data_we_ex_i,
  input  lsu_size_e            data_type_ex_i,
  input  logic [DataWidth-1:0] data_wdata_ex_i,
  input  logic                 data_sign_ext_ex_i,
  input  logic [AddrWidth-1:0] adder_result_ex_i,

  output logic [DataWidth-1:0] data_rdata_ex_o,
  output logic                 data_valid_o,
  output logic                 addr_incr_req_o,
  output logic                 load_err_o,
  output logic                 store_err_o,
  output logic [AddrWidth-1:0] addr_last_o,  // trap value
  output logic                 busy_o,

  // data bus
  output logic                 data_req_o,
  output logic [AddrWidth-1:0] data_addr_o,
  output logic                 data_we_o,
  output logic [NumBytes-1:0]  data_be_o,
  output logic [DataWidth-1:0] data_wdata_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  logic                 data_err_i,
  input  logic [DataWidth-1:0] data_rdata_i
);

  logic misaligned_second;  // split access in its second part
  logic ctrl_update;
  logic rdata_update;

  assign data_we_o = data_we_ex_i;  // held by the core for the whole access

  lsu_fsm #(
    .AddrWidth (AddrWidth)
  ) i_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .data_req_ex_i       (data_req_ex_i),
    .data_we_ex_i        (data_we_ex_i),
    .data_type_ex_i      (data_type_ex_i),
    .adder_result_ex_i   (adder_result_ex_i),
    .data_gnt_i          (data_gnt_i),
    .data_rvalid_i       (data_rvalid_i),
    .data_err_i          (data_err_i),
    .data_req_o          (data_req_o),
    .addr_incr_req_o     (addr_incr_req_o),
    .data_valid_o        (data_valid_o),
    .load_err_o          (load_err_o),
    .store_err_o         (store_err_o),
    .busy_o              (busy_o),
    .addr_last_o         (addr_last_o),
    .misaligned_second_o (misaligned_second),
    .ctrl_update_o       (ctrl_update),
    .rdata_update_o      (rdata_update)
  );

  lsu_wdata_align #(
    .AddrWidth (AddrWidth)
  ) i_wdata (
    .adder_result_ex_i   (adder_result_ex_i),
    .data_type_ex_i      (data_type_ex_i),
    .data_wdata_ex_i     (data_wdata_ex_i),
    .misaligned_second_i (misaligned_second),
    .data_addr_o         (data_addr_o),
    .data_be_o           (data_be_o),
    .data_wdata_o        (data_wdata_o)
  );

  // load path only needs the byte offset
  lsu_rdata_align i_rdata (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ctrl_update_i       (ctrl_update),
    .rdata_update_i      (rdata_update),
    .misaligned_second_i (misaligned_second),
    .adder_result_ex_i   (adder_result_ex_i[OffsetWidth-1:0]),
    .data_type_ex_i      (data_type_ex_i),
    .data_sign_ext_ex_i  (data_sign_ext_ex_i),
    .data_rdata_i        (data_rdata_i),
    .data_rdata_ex_o     (data_rdata_ex_o)
  );

endmodule

// ==== hdl/lsu_wdata_align.sv ====
// store side of the load-store unit
// byte enables per size, offset and part, store data rotated into its
// byte lanes and the word-aligned bus address

module lsu_wdata_align import lsu_pkg::*; #(
  parameter int unsigned AddrWidth = 32
) (
  input  logic [AddrWidth-1:0] adder_result_ex_i,
  input  lsu_size_e            data_type_ex_i,
  input  logic [DataWidth-1:0] data_wdata_ex_i,
  input  logic                 misaligned_second_i,  // second part of a split access

  output logic [AddrWidth-1:0] data_addr_o,
  output logic [NumBytes-1:0]  data_be_o,
  output logic [DataWidth-1:0] data_wdata_o
);

  logic [OffsetWidth-1:0] offset;
  logic [NumBytes-1:0]    be_first;   // lanes from the offset upward
  logic [NumBytes-1:0]    be_second;  // lanes that spill into the next word

  assign offset = adder_result_ex_i[OffsetWidth-1:0];

  //////////////////////////////////////////////////////////////////////
  // byte enables
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (data_type_ex_i)
      size_word: begin
        be_first  = {NumBytes{1'b1}} << offset;
        be_second = ~be_first;  // lanes below the offset, empty when aligned
      end
      size_half: begin
        be_first  = NumBytes'(2'b11) << offset;  // top byte drops out at offset 3
        be_second = NumBytes'(1'b1);             // only lane 0 left over
      end
      default: begin
        // bytes never split
        be_first  = NumBytes'(1'b1) << offset;
        be_second = be_first;
      end
    endcase
  end

  assign data_be_o = misaligned_second_i ? be_second : be_first;

  //////////////////////////////////////////////////////////////////////
  // store data lanes
  //////////////////////////////////////////////////////////////////////

  // rotate left by offset bytes, lane i takes source byte i - offset
  // both parts share the same rotation, the enables pick the lanes
  always_comb begin
    logic [OffsetWidth-1:0] src;
    for (int unsigned i = 0; i < NumBytes; i++) begin
      src = OffsetWidth'(i) - offset;  // wraps modulo four lanes
      data_wdata_o[8*i +: 8] = data_wdata_ex_i[8*src +: 8];
    end
  end

  // bus only sees whole words
  assign data_addr_o = {adder_result_ex_i[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};

endmodule

// ==== tb/tb_lsu.sv ====
// testbench for the load-store unit
// core driver against a bus memory model with random grant and response delays
// and concurrent checks on lanes, split accesses, errors and busy

module tb_lsu import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned MemWords      = 64;
  localparam logic [7:0]  ErrBase       = 8'he0;  // words 56 to 63 answer with an error
  localparam int unsigned TimeoutCycles = 100;
  localparam int unsigned NumRandom     = 400;
  localparam logic [31:0] Seed          = 32'h93f7;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 data_req_ex_i;
  logic                 data_we_ex_i;
  lsu_size_e            data_type_ex_i;
  logic [DataWidth-1:0] data_wdata_ex_i;
  logic                 data_sign_ext_ex_i;
  logic [AddrWidth-1:0] adder_result_ex_i;
  logic [DataWidth-1:0] data_rdata_ex_o;
  logic                 data_valid_o;
  logic                 addr_incr_req_o;
  logic                 load_err_o;
  logic                 store_err_o;
  logic [AddrWidth-1:0] addr_last_o;
  logic                 busy_o;
  logic                 data_req_o;
  logic [AddrWidth-1:0] data_addr_o;
  logic                 data_we_o;
  logic [NumBytes-1:0]  data_be_o;
  logic [DataWidth-1:0] data_wdata_o;
  logic                 data_gnt_i;
  logic                 data_rvalid_i;
  logic                 data_err_i;
  logic [DataWidth-1:0] data_rdata_i;

  typedef struct packed {
    logic [31:0] data;
    logic        err;
    logic [1:0]  delay;  // cycles left before rvalid
  } resp_t;

  logic [31:0] mem [MemWords];       // bus memory model
  logic [7:0]  ref_mem [4*MemWords]; // expected contents per byte address
  resp_t       resp_q [$];           // granted and not yet answered
  logic [31:0] rng_bus;
  logic [31:0] rng_stim;
  int unsigned gnt_delay;

  // current access as issued by the core driver
  logic [31:0] cur_addr;
  lsu_size_e   cur_size;
  logic        cur_we;
  logic        cur_err;
  int unsigned cur_parts;
  int unsigned grant_cnt;  // grants seen in this access
  logic        in_access;  // high from the first request until data_valid_o

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int unsigned size_bytes(input lsu_size_e size);
    case (size)
      size_word: return 4;
      size_half: return 2;
      default:   return 1;  // 2'b11 is a byte too
    endcase
  endfunction

  // lane l is on when byte l of this part's word lies inside the access
  function automatic logic [3:0] expected_be(input lsu_size_e size, input logic [1:0] off,
                                             input int unsigned part);
    logic [3:0]  be;
    int unsigned pos;
    for (int unsigned l = 0; l < 4; l++) begin
      pos   = l + 4 * part;
      be[l] = (pos >= 32'(off)) && (pos < 32'(off) + size_bytes(size));
    end
    return be;
  endfunction

  function automatic logic [7:0] fill_byte(input int unsigned a);
    return 8'(a * 29 + 32'h3c);
  endfunction

  function automatic logic in_err_window(input logic [31:0] a);
    return a[7:0] >= ErrBase;
  endfunction

  // little-endian bytes from the reference with zero or sign fill
  function automatic logic [31:0] expected_load(input logic [31:0] addr, input lsu_size_e size,
                                                input logic sext);
    logic [31:0] val;
    logic [7:0]  top;
    int unsigned n;
    n   = size_bytes(size);
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      val[8*i +: 8] = ref_mem[8'(addr + i)];
    end
    top = val[8*(n-1) +: 8];
    for (int unsigned i = n; i < 4; i++) begin
      val[8*i +: 8] = (sext && top[7]) ? 8'hff : 8'h00;
    end
    return val;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("CHECK FAILED at %0.1f ns: %s", $realtime, msg));
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock and DUT
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  lsu_top #(
    .AddrWidth (AddrWidth)
  ) i_dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .data_req_ex_i      (data_req_ex_i),
    .data_we_ex_i       (data_we_ex_i),
    .data_type_ex_i     (data_type_ex_i),
    .data_wdata_ex_i    (data_wdata_ex_i),
    .data_sign_ext_ex_i (data_sign_ext_ex_i),
    .adder_result_ex_i  (adder_result_ex_i),
    .data_rdata_ex_o    (data_rdata_ex_o),
    .data_valid_o       (data_valid_o),
    .addr_incr_req_o    (addr_incr_req_o),
    .load_err_o         (load_err_o),
    .store_err_o        (store_err_o),
    .addr_last_o        (addr_last_o),
    .busy_o             (busy_o),
    .data_req_o         (data_req_o),
    .data_addr_o        (data_addr_o),
    .data_we_o          (data_we_o),
    .data_be_o          (data_be_o),
    .data_wdata_o       (data_wdata_o),
    .data_gnt_i         (data_gnt_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_err_i         (data_err_i),
    .data_rdata_i       (data_rdata_i)
  );

  //////////////////////////////////////////////////////////////////////
  // bus memory model
  //////////////////////////////////////////////////////////////////////

  initial begin : bus_memory
    resp_t      resp;
    resp_t      head;
    logic [5:0] w;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_err_i    = 1'b0;
    data_rdata_i  = '0;
    gnt_delay     = 0;
    rng_bus       = xorshift(Seed);
    for (int unsigned i = 0; i < 4 * MemWords; i++) begin
      mem[6'(i / 4)][8*(i%4) +: 8] = fill_byte(i);
    end
    forever begin
      @(posedge clk_i);
      #0.5;
      data_gnt_i    = (gnt_delay == 0) && (resp_q.size() < 2);  // two outstanding at most
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
      data_rdata_i  = '0;
      if (gnt_delay != 0) gnt_delay--;
      if (resp_q.size() != 0) begin
        head = resp_q[0];
        if (head.delay == 0) begin
          data_rvalid_i = 1'b1;
          data_err_i    = head.err;
          data_rdata_i  = head.data;
        end else begin
          head.delay--;
          resp_q[0] = head;
        end
      end
      // handshakes of this cycle are settled by the falling edge
      @(negedge clk_i);
      if (data_rvalid_i) void'(resp_q.pop_front());
      if (rst_ni && data_req_o && data_gnt_i) begin
        w = data_addr_o[7:2];
        if (data_we_o && !in_err_window(data_addr_o)) begin
          for (int unsigned l = 0; l < 4; l++) begin
            if (data_be_o[l]) mem[w][8*l +: 8] = data_wdata_o[8*l +: 8];
          end
        end
        rng_bus    = xorshift(rng_bus);
        resp.data  = mem[w];
        resp.err   = in_err_window(data_addr_o);
        resp.delay = rng_bus[1:0];
        resp_q.push_back(resp);
        gnt_delay  = 32'(rng_bus[5:4]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus monitor and concurrent checks
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (!rst_ni || data_valid_o) begin
      grant_cnt <= 0;
      in_access <= 1'b0;
    end else begin
      if (data_req_o) in_access <= 1'b1;
      if (data_req_o && data_gnt_i) grant_cnt <= grant_cnt + 1;
    end
  end

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      data_req_o |-> data_addr_o == ((cur_addr + 4 * grant_cnt) & ~32'h3))
    else report_mismatch("data_addr_o is not the aligned word of the current part");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      data_req_o |-> data_be_o == expected_be(cur_size, cur_addr[1:0], grant_cnt))
    else report_mismatch("data_be_o does not match size, offset and part");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      data_req_o |-> data_we_o == cur_we)
    else report_mismatch("data_we_o differs from the direction of the access");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      data_req_o |-> grant_cnt < cur_parts)
    else report_mismatch("request beyond the expected number of parts");

  // second part only with the core on address + 4
  assert property (@(negedge clk_i) disable iff (!rst_ni)
      (data_req_o && grant_cnt == 1) |-> addr_incr_req_o)
    else report_mismatch("second request without addr_incr_req_o");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      data_valid_o |-> grant_cnt == cur_parts)
    else report_mismatch("data_valid_o after a wrong number of grants");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      data_valid_o |-> (load_err_o == (cur_err && !cur_we)) &&
                       (store_err_o == (cur_err && cur_we)))
    else report_mismatch("load_err_o or store_err_o wrong at data_valid_o");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      !data_valid_o |-> !load_err_o && !store_err_o)
    else report_mismatch("error flag outside the data_valid_o cycle");

  assert property (@(negedge clk_i) disable iff (!rst_ni)
      busy_o == in_access)
    else report_mismatch("busy_o does not cover the access");

  //////////////////////////////////////////////////////////////////////
  // core driver
  //////////////////////////////////////////////////////////////////////

  task automatic run_access(input logic we, input lsu_size_e size, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic sext);
    int unsigned cycles;
    int unsigned n;
    logic [31:0] exp_load;
    logic [31:0] exp_last;
    n = size_bytes(size);
    @(posedge clk_i);
    #0.5;
    cur_addr  = addr;
    cur_size  = size;
    cur_we    = we;
    cur_parts = (32'(addr[1:0]) + n > 4) ? 2 : 1;  // crosses the word boundary
    cur_err   = in_err_window(addr) || (cur_parts == 2 && in_err_window(addr + 4));
    exp_last  = in_err_window(addr) ? addr : addr + 4;  // first failing part
    exp_load  = expected_load(addr, size, sext);
    data_we_ex_i       = we;
    data_type_ex_i     = size;
    data_wdata_ex_i    = wdata;
    data_sign_ext_ex_i = sext;
    adder_result_ex_i  = addr;
    data_req_ex_i      = 1'b1;
    cycles = 0;
    @(negedge clk_i);
    while (!data_valid_o) begin
      cycles++;
      if (cycles > TimeoutCycles) begin
        abort_run($sformatf("timeout: no data_valid_o for the access at %08h", addr));
      end
      @(posedge clk_i);
      #0.5;
      adder_result_ex_i = addr_incr_req_o ? addr + 4 : addr;  // same low bits
      @(negedge clk_i);
    end
    if (cur_err) begin
      assert (addr_last_o == exp_last)
        else report_mismatch($sformatf("addr_last_o %08h, expected %08h",
                                       addr_last_o, exp_last));
    end else if (!we) begin
      assert (data_rdata_ex_o == exp_load)
        else report_mismatch($sformatf("load at %08h size %0d returned %08h, expected %08h",
                                       addr, n, data_rdata_ex_o, exp_load));
    end
    if (we) begin
      for (int unsigned i = 0; i < n; i++) begin
        if (!in_err_window(addr + i)) ref_mem[8'(addr + i)] = wdata[8*i +: 8];
      end
    end
    @(posedge clk_i);
    #0.5;
    data_req_ex_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] addr;
    logic [31:0] wdata;
    lsu_size_e   rnd_size;
    data_req_ex_i      = 1'b0;
    data_we_ex_i       = 1'b0;
    data_type_ex_i     = size_word;
    data_wdata_ex_i    = '0;
    data_sign_ext_ex_i = 1'b0;
    adder_result_ex_i  = '0;
    cur_addr  = '0;
    cur_size  = size_word;
    cur_we    = 1'b0;
    cur_err   = 1'b0;
    cur_parts = 1;
    rng_stim  = Seed;
    rst_ni    = 1'b0;
    for (int unsigned i = 0; i < 4 * MemWords; i++) begin
      ref_mem[8'(i)] = fill_byte(i);
    end
    repeat (3) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (!data_req_o && !data_valid_o && !addr_incr_req_o && !load_err_o &&
            !store_err_o && !busy_o && addr_last_o == '0)
      else report_mismatch("outputs not cleared after reset");

    // aligned stores and loads with both extensions
    run_access(1'b1, size_word, 32'h10, 32'h8bad_f00d, 1'b0);
    run_access(1'b0, size_word, 32'h10, '0, 1'b0);
    run_access(1'b1, size_half, 32'h16, 32'h0000_9abc, 1'b0);
    run_access(1'b0, size_half, 32'h16, '0, 1'b1);
    run_access(1'b0, size_half, 32'h16, '0, 1'b0);
    run_access(1'b1, size_byte, 32'h21, 32'h0000_0081, 1'b0);
    run_access(1'b0, size_byte, 32'h21, '0, 1'b1);
    run_access(1'b0, size_byte, 32'h21, '0, 1'b0);
    run_access(1'b1, size_byte, 32'h22, 32'h0000_007f, 1'b0);
    run_access(1'b0, size_byte, 32'h22, '0, 1'b1);

    // split words and the top-lane half word
    for (int unsigned off = 1; off < 4; off++) begin
      run_access(1'b1, size_word, 32'h40 + off, 32'hc0de_a500 | off, 1'b0);
      run_access(1'b0, size_word, 32'h40 + off, '0, 1'b0);
    end
    run_access(1'b1, size_half, 32'h53, 32'h0000_f00f, 1'b0);
    run_access(1'b0, size_half, 32'h53, '0, 1'b1);

    // bus errors on the first part, the second part, or both
    run_access(1'b0, size_word, 32'he4, '0, 1'b0);
    run_access(1'b1, size_byte, 32'he9, 32'h0000_0055, 1'b0);
    run_access(1'b0, size_word, 32'hde, '0, 1'b0);
    run_access(1'b1, size_half, 32'hdf, 32'h0000_1234, 1'b0);
    run_access(1'b0, size_word, 32'he1, '0, 1'b0);
    run_access(1'b1, size_word, 32'hf3, 32'h5a5a_a5a5, 1'b0);

    // random accesses clear of the error window
    for (int unsigned k = 0; k < NumRandom; k++) begin
      rng_stim = xorshift(rng_stim);
      addr     = rng_stim % 32'hdc;
      rnd_size = lsu_size_e'(rng_stim[9:8]);
      wdata    = xorshift(rng_stim ^ 32'h5bd1);
      run_access(rng_stim[10], rnd_size, addr, wdata, rng_stim[11]);
    end

    for (int unsigned w = 0; w < MemWords; w++) begin
      for (int unsigned b = 0; b < 4; b++) begin
        assert (mem[6'(w)][8*b +: 8] == ref_mem[8'(4*w + b)])
          else report_mismatch($sformatf("memory byte %02h differs from reference", 4*w + b));
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
